/* fmul_params.svh */
`ifndef FMUL_PARAMS_SVH
`define FMUL_PARAMS_SVH

// Exponent bias of binary32.
`define FMUL_BIAS 127

// The signed internal exponent holds the unbounded sum of two biased exponents.
`define FMUL_EXP_W 10

// Stored fraction width and the all-ones exponent code.
`define FMUL_FRAC_W 23
`define FMUL_EXP_INF 8'hFF

// Width of the sideband tag carried with every operation.
`define FMUL_TAG_W 4

// Canonical quiet NaN returned for every NaN result.
`define FMUL_QNAN 32'h7FC00000

`endif

/* fmul_pkg.sv */
`default_nettype none

`include "fmul_params.svh"

package fmul_pkg;

    // Class of an operand, and the resolved special class of a product.
    typedef enum logic [2:0] {
        CLS_ZERO,
        CLS_NORMAL,
        CLS_INF,
        CLS_QNAN,
        CLS_SNAN
    } fmul_class_e;

    // Exception flags in the order they appear on the output bus.
    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fmul_flags_t;

    // Significand with the hidden bit restored.
    typedef logic [23:0] fmul_sig_t;

    // Full significand product.
    typedef logic [47:0] fmul_prod_t;

    // Biased exponent sum. It may leave the 8-bit range in either direction.
    typedef logic signed [`FMUL_EXP_W-1:0] fmul_exp_t;

    // Field view of a binary32 word.
    typedef struct packed {
        logic sign;
        logic [7:0] exp;
        logic [`FMUL_FRAC_W-1:0] frac;
    } fmul_float_t;

endpackage

`default_nettype wire

/* fmul_exp_intf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

interface fmul_exp_intf;
    import fmul_pkg::*;

    logic valid;
    logic ready;
    logic sign;
    fmul_exp_t exp_sum; // Biased once, not yet range checked.
    fmul_class_e res_class;
    logic invalid;
    logic [`FMUL_TAG_W-1:0] tag;

    modport src (
        output valid, sign, exp_sum, res_class, invalid, tag,
        input ready
    );

    modport dst (
        input valid, sign, exp_sum, res_class, invalid, tag,
        output ready
    );

endinterface

`default_nettype wire

/* fmul_exponent.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

module fmul_exponent (
    input logic clk,
    input logic rst,

    input logic in_valid,
    output logic in_ready,
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [`FMUL_TAG_W-1:0] tag,

    fmul_exp_intf.src exp_out
);
    import fmul_pkg::*;

    fmul_float_t fa, fb;
    fmul_class_e cls_a, cls_b;
    fmul_class_e next_class;
    fmul_exp_t next_exp;
    logic next_invalid;
    logic any_nan, inf_zero;

    // Subnormals are read as zero, so only the exponent field decides zero.
    function automatic fmul_class_e classify(input fmul_float_t x);
        if (x.exp == 8'd0) begin
            return CLS_ZERO;
        end else if (x.exp == `FMUL_EXP_INF) begin
            if (x.frac == '0) begin
                return CLS_INF;
            end else if (x.frac[`FMUL_FRAC_W-1]) begin
                return CLS_QNAN;
            end
            return CLS_SNAN;
        end
        return CLS_NORMAL;
    endfunction

    assign fa = a;
    assign fb = b;
    assign cls_a = classify(fa);
    assign cls_b = classify(fb);

    assign any_nan = (cls_a inside {CLS_QNAN, CLS_SNAN}) || (cls_b inside {CLS_QNAN, CLS_SNAN});
    assign inf_zero = (cls_a == CLS_INF && cls_b == CLS_ZERO) ||
                      (cls_a == CLS_ZERO && cls_b == CLS_INF);

    always_comb begin
        if (any_nan || inf_zero) begin
            next_class = CLS_QNAN;
        end else if (cls_a == CLS_INF || cls_b == CLS_INF) begin
            next_class = CLS_INF;
        end else if (cls_a == CLS_ZERO || cls_b == CLS_ZERO) begin
            next_class = CLS_ZERO;
        end else begin
            next_class = CLS_NORMAL;
        end
    end

    assign next_invalid = cls_a == CLS_SNAN || cls_b == CLS_SNAN || inf_zero;

    assign next_exp = fmul_exp_t'({{(`FMUL_EXP_W-8){1'b0}}, fa.exp}) +
                      fmul_exp_t'({{(`FMUL_EXP_W-8){1'b0}}, fb.exp}) -
                      fmul_exp_t'(`FMUL_BIAS);

    // One-entry stage that can refill in the cycle it is drained.
    assign in_ready = !exp_out.valid || exp_out.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_out.valid <= 1'b0;
        end else if (in_ready) begin
            exp_out.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            exp_out.sign <= fa.sign ^ fb.sign;
            exp_out.exp_sum <= next_exp;
            exp_out.res_class <= next_class;
            exp_out.invalid <= next_invalid;
            exp_out.tag <= tag;
        end
    end

endmodule

`default_nettype wire

/* fmul_mantissa.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

module fmul_mantissa (
    input logic clk,
    input logic rst,

    input logic in_valid,
    output logic in_ready,
    input logic [31:0] a,
    input logic [31:0] b,

    output logic man_valid,
    input logic man_ready,
    output fmul_pkg::fmul_prod_t man_prod
);
    import fmul_pkg::*;

    fmul_float_t fa, fb;
    fmul_sig_t sig_a, sig_b;
    fmul_prod_t next_prod;

    assign fa = a;
    assign fb = b;

    // The hidden bit is always set here. Zero, infinity and NaN operands
    // produce a meaningless product that the combine stage overrides.
    assign sig_a = {1'b1, fa.frac[`FMUL_FRAC_W-1:0]};
    assign sig_b = {1'b1, fb.frac[`FMUL_FRAC_W-1:0]};

    assign next_prod = sig_a * sig_b; // Both factors are in [1, 2), so bit 47 or 46 leads.

    assign in_ready = !man_valid || man_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            man_valid <= 1'b0;
        end else if (in_ready) begin
            man_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            man_prod <= next_prod;
        end
    end

endmodule

`default_nettype wire

/* fmul_combine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

module fmul_combine (
    input logic clk,
    input logic rst,

    fmul_exp_intf.dst exp_in,

    input logic man_valid,
    output logic man_ready,
    input fmul_pkg::fmul_prod_t man_prod,

    output logic out_valid,
    input logic out_ready,
    output logic [31:0] out_result,
    output fmul_pkg::fmul_flags_t out_flags,
    output logic [`FMUL_TAG_W-1:0] out_tag
);
    import fmul_pkg::*;

    logic out_can, both_valid, join_ready;
    logic hi;
    fmul_sig_t sig_n, sig_f;
    logic [24:0] sig_r;
    logic guard, sticky, round_up;
    fmul_exp_t exp_n, exp_f;
    logic [31:0] next_result;
    fmul_flags_t next_flags;

    // Both paths are taken on the same edge, so they never drift apart.
    assign out_can = !out_valid || out_ready;
    assign both_valid = exp_in.valid && man_valid;
    assign join_ready = both_valid && out_can;
    assign exp_in.ready = join_ready;
    assign man_ready = join_ready;

    // Normalize to a 24-bit window below the leading one.
    assign hi = man_prod[47];
    assign sig_n = hi ? man_prod[47:24] : man_prod[46:23];
    assign guard = hi ? man_prod[23] : man_prod[22];
    assign sticky = hi ? |man_prod[22:0] : |man_prod[21:0];
    assign exp_n = exp_in.exp_sum + fmul_exp_t'(hi);

    // Nearest-even. A tie rounds up only when the kept LSB is odd.
    assign round_up = guard && (sticky || sig_n[0]);
    assign sig_r = {1'b0, sig_n} + 25'(round_up);

    always_comb begin
        if (sig_r[24]) begin
            sig_f = sig_r[24:1]; // Carry out leaves 1.000...; shift back into the window.
            exp_f = exp_n + fmul_exp_t'(1);
        end else begin
            sig_f = sig_r[23:0];
            exp_f = exp_n;
        end
    end

    always_comb begin
        next_flags = '0;
        next_flags.invalid = exp_in.invalid;
        case (exp_in.res_class)
            CLS_QNAN: begin
                next_result = `FMUL_QNAN;
            end
            CLS_INF: begin
                next_result = {exp_in.sign, `FMUL_EXP_INF, {`FMUL_FRAC_W{1'b0}}};
            end
            CLS_ZERO: begin
                next_result = {exp_in.sign, 31'd0};
            end
            default: begin
                if (exp_f >= 255) begin
                    next_result = {exp_in.sign, `FMUL_EXP_INF, {`FMUL_FRAC_W{1'b0}}};
                    next_flags.overflow = 1'b1;
                    next_flags.inexact = 1'b1;
                end else if (exp_f <= 0) begin
                    // No subnormal results. Tiny products flush to zero.
                    next_result = {exp_in.sign, 31'd0};
                    next_flags.underflow = 1'b1;
                    next_flags.inexact = 1'b1;
                end else begin
                    next_result = {exp_in.sign, exp_f[7:0], sig_f[`FMUL_FRAC_W-1:0]};
                    next_flags.inexact = guard || sticky;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_can) begin
            out_valid <= both_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (join_ready) begin
            out_result <= next_result;
            out_flags <= next_flags;
            out_tag <= exp_in.tag;
        end
    end

endmodule

`default_nettype wire

/* fmul_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

module fmul_top (
    input logic clk,
    input logic rst,

    input logic in_valid,
    output logic in_ready,
    input logic [31:0] in_a,
    input logic [31:0] in_b,
    input logic [`FMUL_TAG_W-1:0] in_tag,

    output logic out_valid,
    input logic out_ready,
    output logic [31:0] out_result,
    output fmul_pkg::fmul_flags_t out_flags,
    output logic [`FMUL_TAG_W-1:0] out_tag
);

    logic exp_in_ready, man_in_ready;
    logic exp_in_valid, man_in_valid;
    logic man_valid, man_ready;
    logic [47:0] man_prod;

    fmul_exp_intf exp_bus ();

    // Each side only sees valid when the other side can take the same operation.
    assign in_ready = exp_in_ready && man_in_ready;
    assign exp_in_valid = in_valid && man_in_ready;
    assign man_in_valid = in_valid && exp_in_ready;

    fmul_exponent fmul_exponent_inst (
        .clk,
        .rst,
        .in_valid(exp_in_valid),
        .in_ready(exp_in_ready),
        .a(in_a),
        .b(in_b),
        .tag(in_tag),
        .exp_out(exp_bus.src)
    );

    fmul_mantissa fmul_mantissa_inst (
        .clk,
        .rst,
        .in_valid(man_in_valid),
        .in_ready(man_in_ready),
        .a(in_a),
        .b(in_b),
        .man_valid,
        .man_ready,
        .man_prod
    );

    fmul_combine fmul_combine_inst (
        .clk,
        .rst,
        .exp_in(exp_bus.dst),
        .man_valid,
        .man_ready,
        .man_prod,
        .out_valid,
        .out_ready,
        .out_result,
        .out_flags,
        .out_tag
    );

endmodule

`default_nettype wire

/* tb_fmul_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

module tb_fmul_checker (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready,
    input logic [31:0] out_result,
    input fmul_pkg::fmul_flags_t out_flags,
    input logic [`FMUL_TAG_W-1:0] out_tag
);
    import fmul_pkg::*;

    // Result, flags and tag of one operation.
    localparam int ENTRY_W = 32 + 4 + `FMUL_TAG_W;

    logic [ENTRY_W-1:0] expect_q[$];
    int unsigned out_count = 0;
    int unsigned error_count = 0;
    int unsigned in_flight = 0; // Accepted but not yet delivered.

    task automatic push_expect(input logic [ENTRY_W-1:0] entry);
        expect_q.push_back(entry);
    endtask

    always @(posedge clk) begin
        logic [ENTRY_W-1:0] expected;
        if (rst) begin
            in_flight = 0;
        end else begin
            // Exponent/mantissa stage and output register both hold an operation.
            if (out_valid && !out_ready && in_flight >= 2 && in_ready) begin
                $display("Error: time %0t: in_ready high while %0d held and output stalled",
                         $time, in_flight);
                error_count++;
            end
            if (in_valid && in_ready) begin
                in_flight++;
            end
            if (out_valid && out_ready) begin
                out_count++;
                if (in_flight > 0) begin
                    in_flight--;
                end
                if (expect_q.size() == 0) begin
                    $display("Output tag %0h at time %0t came with no operation pending.",
                             out_tag, $time);
                    error_count++;
                end else begin
                    expected = expect_q.pop_front();
                    if ({out_result, out_flags, out_tag} !== expected) begin
                        $display("Error: time %0t: got %h/%b/%h, expected %h/%b/%h",
                                 $time, out_result, out_flags, out_tag,
                                 expected[ENTRY_W-1:`FMUL_TAG_W+4],
                                 expected[`FMUL_TAG_W+3:`FMUL_TAG_W],
                                 expected[`FMUL_TAG_W-1:0]);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_fmul.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fmul_params.svh"

module tb_fmul;
    import fmul_pkg::*;

    localparam integer SEED = 32'hdb9f;
    localparam int PHASE1_OPS = 40;
    localparam int PHASE2_OPS = 400;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int ENTRY_W = 32 + 4 + `FMUL_TAG_W;

    logic clk = 1'b0;
    logic rst, in_valid, in_ready, out_valid, out_ready;
    logic [31:0] in_a, in_b, out_result;
    logic [`FMUL_TAG_W-1:0] in_tag, out_tag;
    fmul_flags_t out_flags;

    integer seed, ready_seed;
    int unsigned sent, tb_errors, stalls, waited, cycle;
    int unsigned first_in_cycle, first_out_cycle;
    logic random_ready, timed_out, seen_in, seen_out;
    logic [31:0] op_a, op_b;

    always #2 clk = ~clk;

    fmul_top fmul_top_inst (.*);

    tb_fmul_checker checker_inst (.*);

    // Expected result from the IEEE rules, with subnormals flushed and nearest-even rounding.
    function automatic logic [ENTRY_W-1:0] fmul_ref(input logic [31:0] a, input logic [31:0] b,
                                                    input logic [`FMUL_TAG_W-1:0] tag);
        logic sign, a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, inf_zero;
        logic [31:0] res;
        logic [63:0] prod, sig, rem, half;
        fmul_flags_t flags;
        int e, shift;
        sign = a[31] ^ b[31];
        a_zero = a[30:23] == 8'd0;
        b_zero = b[30:23] == 8'd0;
        a_inf = a[30:23] == 8'hFF && a[22:0] == 23'd0;
        b_inf = b[30:23] == 8'hFF && b[22:0] == 23'd0;
        a_nan = a[30:23] == 8'hFF && a[22:0] != 23'd0;
        b_nan = b[30:23] == 8'hFF && b[22:0] != 23'd0;
        inf_zero = (a_inf && b_zero) || (a_zero && b_inf);
        flags = '0;
        flags.invalid = (a_nan && !a[22]) || (b_nan && !b[22]) || inf_zero;
        if (a_nan || b_nan || inf_zero) begin
            res = `FMUL_QNAN;
        end else if (a_inf || b_inf) begin
            res = {sign, 8'hFF, 23'd0};
        end else if (a_zero || b_zero) begin
            res = {sign, 31'd0};
        end else begin
            prod = {40'd0, 1'b1, a[22:0]} * {40'd0, 1'b1, b[22:0]};
            e = int'(a[30:23]) + int'(b[30:23]) - `FMUL_BIAS;
            shift = 23;
            if (prod >= (64'd1 << 47)) begin
                shift = 24;
                e = e + 1;
            end
            sig = prod >> shift;
            rem = prod - (sig << shift);
            half = 64'd1 << (shift - 1);
            if (rem > half || (rem == half && sig[0])) begin
                sig = sig + 64'd1;
            end
            if (sig == (64'd1 << 24)) begin
                sig = sig >> 1;
                e = e + 1;
            end
            if (e >= 255) begin
                res = {sign, 8'hFF, 23'd0};
                flags.overflow = 1'b1;
                flags.inexact = 1'b1;
            end else if (e <= 0) begin
                res = {sign, 31'd0};
                flags.underflow = 1'b1;
                flags.inexact = 1'b1;
            end else begin
                res = {sign, 8'(e), sig[22:0]};
                flags.inexact = rem != 64'd0;
            end
        end
        return {res, flags, tag};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Normal number with a biased exponent in [lo, hi].
    function automatic logic [31:0] rand_float(input int lo, input int hi);
        logic [31:0] r;
        int e;
        r = rand_word();
        e = lo + int'(rand_word() % 32'(hi - lo + 1));
        return {r[31], 8'(e), r[22:0]};
    endfunction

    function automatic logic [31:0] pick_special();
        case (rand_word() % 32'd11)
            0: return 32'h00000000;
            1: return 32'h80000000;
            2: return 32'h7F800000;
            3: return 32'hFF800000;
            4: return 32'h7FC00001; // Quiet NaN.
            5: return 32'hFF800001; // Signaling NaN.
            6: return 32'h00000123;
            7: return 32'h807FFFFF;
            8: return 32'h7F7FFFFF;
            9: return 32'h00800000;
            default: return 32'h3F800000;
        endcase
    endfunction

    task automatic make_operands(output logic [31:0] a, output logic [31:0] b);
        logic [31:0] r;
        r = rand_word();
        a = rand_float(64, 190);
        b = rand_float(64, 190);
        case (rand_word() % 32'd10)
            4: begin
                // Odd significand below 0xA00000 times 1.5 lands exactly on a half.
                a = {r[31], a[30:23], 2'b00, r[20:1], 1'b1};
                b = {r[30], b[30:23], 23'h400000};
            end
            5: if (r[0]) a = pick_special(); else b = pick_special();
            6: begin
                a = pick_special();
                b = pick_special();
            end
            7: begin
                a = rand_float(190, 254);
                b = rand_float(190, 254);
            end
            8: begin
                a = rand_float(1, 63);
                b = rand_float(1, 63);
            end
            9: a = {r[31], r[1] ? 31'h7F7FFFFF : 31'h00800000};
            default: ;
        endcase
    endtask

    // Holds the operation on the bus until the DUT takes it.
    task automatic send_op(input logic [31:0] a, input logic [31:0] b);
        int wait_cycles;
        wait_cycles = 0;
        if (timed_out) return;
        in_valid = 1'b1;
        in_a = a;
        in_b = b;
        in_tag = sent[`FMUL_TAG_W-1:0];
        @(posedge clk);
        while (!in_ready && wait_cycles < READY_TIMEOUT) begin
            wait_cycles++;
            @(posedge clk);
        end
        if (!in_ready) begin
            $display("The DUT did not accept an operation within %0d cycles.", READY_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            checker_inst.push_expect(fmul_ref(a, b, in_tag));
            sent++;
            if (!random_ready) stalls += wait_cycles;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst && in_valid && in_ready && !seen_in) begin
            seen_in = 1'b1;
            first_in_cycle = cycle;
        end
        if (!rst && out_valid && out_ready && !seen_out) begin
            seen_out = 1'b1;
            first_out_cycle = cycle;
        end
        cycle++;
    end

    // The back-pressure pattern changes every 32 cycles.
    initial begin
        int mode;
        mode = 0;
        ready_seed = SEED + 1;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (!random_ready) begin
                out_ready = 1'b1;
            end else begin
                if (cycle % 32 == 0) mode = int'($unsigned($random(ready_seed)) % 3);
                case (mode)
                    0: out_ready = ($random(ready_seed) & 7) != 0;
                    1: out_ready = ($random(ready_seed) & 7) == 0;
                    default: out_ready = ($random(ready_seed) & 1) != 0;
                endcase
            end
        end
    end

    initial begin
        seed = SEED;
        rst = 1'b1;
        in_valid = 1'b0;
        in_a = '0;
        in_b = '0;
        in_tag = '0;
        {sent, tb_errors, stalls, cycle, first_in_cycle, first_out_cycle} = '0;
        {random_ready, timed_out, seen_in, seen_out} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("Error: time %0t: after reset out_valid %b in_ready %b",
                     $time, out_valid, in_ready);
            tb_errors++;
        end
        for (int i = 0; i < PHASE1_OPS; i++) begin
            make_operands(op_a, op_b);
            send_op(op_a, op_b);
        end
        random_ready = 1'b1;
        for (int i = 0; i < PHASE2_OPS; i++) begin
            if (rand_word() % 32'd4 == 0) repeat (1 + rand_word() % 32'd3) @(negedge clk);
            make_operands(op_a, op_b);
            send_op(op_a, op_b);
        end
        random_ready = 1'b0;
        waited = 0;
        while (checker_inst.out_count < sent && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (checker_inst.out_count < sent) begin
            $display("%0d accepted operations never came out.", sent - checker_inst.out_count);
            tb_errors++;
        end
        if (!seen_out || first_out_cycle - first_in_cycle != 2) begin
            $display("Error: time %0t: first result after %0d cycles, expected 2",
                     $time, first_out_cycle - first_in_cycle);
            tb_errors++;
        end
        if (stalls != 0) begin
            $display("Error: time %0t: in_ready low for %0d cycles with out_ready high",
                     $time, stalls);
            tb_errors++;
        end
        $display("Sent %0d, received %0d, checker errors %0d, testbench errors %0d",
                 sent, checker_inst.out_count, checker_inst.error_count, tb_errors);
        if (!timed_out && tb_errors == 0 && checker_inst.error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
fmul_pkg.sv
fmul_exp_intf.sv
fmul_exponent.sv
fmul_mantissa.sv
fmul_combine.sv
fmul_top.sv
tb_fmul_checker.sv
tb_fmul.sv

/* run.sh */
#!/bin/sh
# Build and run the fmul regression with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_fmul \
    --Mdir obj_dir -o tb_fmul_sim || exit 1
sim_out=$(./obj_dir/tb_fmul_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Regression passed" && exit 0 || exit 1
